//--- Makefile
# Verilator build and run of the ALU cluster testbench.

VERILATOR ?= verilator
TOP       ?= tb_alu_cluster
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^TESTBENCH PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
alu_cfg_pkg.sv
alu_bus_pkg.sv
alu_shifter.sv
operand_forward.sv
alu_op_decode.sv
alu_lane.sv
alu_cluster.sv
tb_alu_cluster.sv

//--- alu_bus_pkg.sv
// Issue, forwarding select, decoded control and result bus structs.
`default_nettype none

package alu_bus_pkg;

  import alu_cfg_pkg::*;

  // Where an operand comes from.
  typedef enum logic [1:0] {
    fwd_reg  = 2'd0,
    fwd_now  = 2'd1,
    fwd_prev = 2'd2
  } fwd_src_e;

  typedef struct packed {
    fwd_src_e              src;
    logic [lane_idx_w-1:0] idx;
  } fwd_sel_t;

  // One issued operation.
  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    logic     wide;
    tag_t     tag;
    data_t    a;
    data_t    b;
    fwd_sel_t a_fwd;
    fwd_sel_t b_fwd;
  } alu_issue_t;

  // Lsel_arith routes the adder result.
  typedef enum logic [1:0] {
    lsel_arith = 2'd0,
    lsel_and   = 2'd1,
    lsel_or    = 2'd2,
    lsel_xor   = 2'd3
  } logic_sel_e;

  typedef struct packed {
    logic       valid;
    tag_t       tag;
    logic       is_sub;
    logic_sel_e logic_sel;
    logic       is_shift;
    logic       shift_left;
    logic       shift_arith;
    logic       wide;
  } alu_ctrl_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t data;
  } alu_result_t;

endpackage

`default_nettype wire

//--- alu_cfg_pkg.sv
// Datapath widths, lane-count limits, operation codes and base data types.
`default_nettype none

package alu_cfg_pkg;

  // Operand and result width, and the width of the narrow operations.
  localparam int unsigned data_w = 64;
  localparam int unsigned half_w = 32;

  // Return tag carried with every operation.
  localparam int unsigned tag_w = 6;

  // The bus index field can address at most max_lanes result buses.
  localparam int unsigned max_lanes  = 4;
  localparam int unsigned lane_idx_w = 2;

  // Operation codes.
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_shl = 3'd5,
    op_shr = 3'd6,
    op_sar = 3'd7
  } alu_op_e;

  typedef logic [data_w-1:0] data_t;
  typedef logic [tag_w-1:0]  tag_t;

endpackage

`default_nettype wire

//--- alu_cluster.sv
// Cluster top level with the lane instances and their shared result bus array.
`default_nettype none

module alu_cluster
  import alu_cfg_pkg::*, alu_bus_pkg::*;
#(
  parameter int lanes = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  alu_issue_t  [lanes-1:0] issue,
  output alu_result_t [lanes-1:0] result
);

  // Every lane drives one entry and reads all of them.
  alu_result_t [lanes-1:0] bus;

  // The forwarding index field cannot reach more than max_lanes buses.
  if (lanes < 1 || lanes > int'(max_lanes)) begin : g_lanes_check
    $error("alu_cluster: lanes must be between 1 and %0d", max_lanes);
  end

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    alu_lane #(
      .lanes(lanes)
    ) u_lane (
      .clk    (clk),
      .rst_n  (rst_n),
      .issue  (issue[i]),
      .bus    (bus),
      .result (bus[i])
    );
  end

  assign result = bus;

endmodule

`default_nettype wire

//--- alu_lane.sv
// One execution lane with operand forwarding, decode, execute and result register.
`default_nettype none

module alu_lane
  import alu_cfg_pkg::*, alu_bus_pkg::*;
#(
  parameter int lanes = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  alu_issue_t              issue,
  input  alu_result_t [lanes-1:0] bus,
  output alu_result_t             result
);

  data_t     op_a;
  data_t     op_b;
  alu_ctrl_t ctrl;
  data_t     a_q;
  data_t     b_q;
  data_t     sum;
  data_t     sh_val;
  data_t     exec_val;
  logic      res_valid;
  tag_t      res_tag;
  data_t     res_data;

  operand_forward #(
    .lanes(lanes)
  ) u_fwd_a (
    .clk     (clk),
    .rst_n   (rst_n),
    .reg_val (issue.a),
    .sel     (issue.a_fwd),
    .bus     (bus),
    .operand (op_a)
  );

  operand_forward #(
    .lanes(lanes)
  ) u_fwd_b (
    .clk     (clk),
    .rst_n   (rst_n),
    .reg_val (issue.b),
    .sel     (issue.b_fwd),
    .bus     (bus),
    .operand (op_b)
  );

  alu_op_decode u_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (issue),
    .op_a  (op_a),
    .op_b  (op_b),
    .ctrl  (ctrl),
    .a     (a_q),
    .b     (b_q)
  );

  alu_shifter u_shifter (
    .value   (a_q),
    .amount  (b_q[5:0]),
    .wide    (ctrl.wide),
    .left    (ctrl.shift_left),
    .arith   (ctrl.shift_arith),
    .shifted (sh_val)
  );

  // Subtract as A plus inverted B plus one.
  assign sum = a_q + (b_q ^ {data_w{ctrl.is_sub}}) + data_t'(ctrl.is_sub);

  always_comb begin
    case (ctrl.logic_sel)
      lsel_and: exec_val = a_q & b_q;
      lsel_or:  exec_val = a_q | b_q;
      lsel_xor: exec_val = a_q ^ b_q;
      default:  exec_val = sum;
    endcase
    if (ctrl.is_shift) begin
      exec_val = sh_val;
    end
    // Narrow results leave the upper half clear.
    if (!ctrl.wide) begin
      exec_val[data_w-1:half_w] = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= ctrl.valid;
    end
  end

  always_ff @(posedge clk) begin
    res_tag  <= ctrl.tag;
    res_data <= exec_val;
  end

  assign result = '{valid: res_valid, tag: res_tag, data: res_data};

endmodule

`default_nettype wire

//--- alu_op_decode.sv
// Registered decode of an issued operation into execution controls and operands.
`default_nettype none

module alu_op_decode
  import alu_cfg_pkg::*, alu_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  alu_issue_t issue,
  input  data_t      op_a,
  input  data_t      op_b,
  output alu_ctrl_t  ctrl,
  output data_t      a,
  output data_t      b
);

  alu_ctrl_t ctrl_d;

  always_comb begin
    ctrl_d       = '0;
    ctrl_d.valid = issue.valid;
    ctrl_d.tag   = issue.tag;
    ctrl_d.wide  = issue.wide;
    case (issue.op)
      op_sub: begin
        ctrl_d.is_sub = 1'b1;
      end
      op_and: begin
        ctrl_d.logic_sel = lsel_and;
      end
      op_or: begin
        ctrl_d.logic_sel = lsel_or;
      end
      op_xor: begin
        ctrl_d.logic_sel = lsel_xor;
      end
      op_shl: begin
        ctrl_d.is_shift   = 1'b1;
        ctrl_d.shift_left = 1'b1;
      end
      op_shr: begin
        ctrl_d.is_shift = 1'b1;
      end
      op_sar: begin
        ctrl_d.is_shift    = 1'b1;
        ctrl_d.shift_arith = 1'b1;
      end
      // Add uses the cleared defaults.
      default: begin
        ctrl_d.logic_sel = lsel_arith;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl <= '0;
    end else begin
      ctrl <= ctrl_d;
    end
  end

  always_ff @(posedge clk) begin
    a <= op_a;
    b <= op_b;
  end

endmodule

`default_nettype wire

//--- alu_shifter.sv
// Combinational 64-bit and 32-bit shift left, logical and arithmetic shift right.
`default_nettype none

module alu_shifter
  import alu_cfg_pkg::*;
(
  input  data_t      value,
  input  logic [5:0] amount,
  input  logic       wide,
  input  logic       left,
  input  logic       arith,
  output data_t      shifted
);

  logic [half_w-1:0] lo;
  logic [4:0]        amount_lo;
  logic [half_w-1:0] lo_res;
  data_t             full_res;

  // Narrow shifts see only the low half and five amount bits.
  assign lo        = value[half_w-1:0];
  assign amount_lo = amount[4:0];

  always_comb begin
    if (left) begin
      full_res = value << amount;
      lo_res   = lo << amount_lo;
    end else if (arith) begin
      full_res = $signed(value) >>> amount;
      lo_res   = $signed(lo) >>> amount_lo;
    end else begin
      full_res = value >> amount;
      lo_res   = lo >> amount_lo;
    end
  end

  // Narrow result is zero-extended.
  assign shifted = wide ? full_res : {{(data_w - half_w){1'b0}}, lo_res};

endmodule

`default_nettype wire

//--- operand_forward.sv
// Operand source selection from the register value or the current or previous result buses.
`default_nettype none

module operand_forward
  import alu_cfg_pkg::*, alu_bus_pkg::*;
#(
  parameter int lanes = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  data_t                   reg_val,
  input  fwd_sel_t                sel,
  input  alu_result_t [lanes-1:0] bus,
  output data_t                   operand
);

  data_t prev_data [lanes];
  data_t now_val;
  data_t prev_val;

  // Copy of every bus as it stood at the last edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < lanes; i++) begin
        prev_data[i] <= '0;
      end
    end else begin
      for (int i = 0; i < lanes; i++) begin
        prev_data[i] <= bus[i].data;
      end
    end
  end

  // Bus valid is ignored; an index past the last lane reads zero.
  always_comb begin
    now_val  = '0;
    prev_val = '0;
    for (int i = 0; i < lanes; i++) begin
      if (int'(sel.idx) == i) begin
        now_val  = bus[i].data;
        prev_val = prev_data[i];
      end
    end
  end

  always_comb begin
    case (sel.src)
      fwd_now:  operand = now_val;
      fwd_prev: operand = prev_val;
      default:  operand = reg_val;
    endcase
  end

endmodule

`default_nettype wire

//--- tb_alu_cluster.sv
// Testbench for the ALU cluster with random stimulus, a reference model and a result checker.
`default_nettype none

module tb_alu_cluster
  import alu_cfg_pkg::*, alu_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int lanes       = 2;
  localparam int rand_cycles = 400;
  localparam int drain_limit = 20;
  localparam int shift_amts [6] = '{0, 1, 31, 32, 33, 63};

  // Expected bus contents for one cycle, checked after edge number due.
  typedef struct packed {
    logic [31:0]             due;
    alu_result_t [lanes-1:0] res;
  } expect_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  alu_issue_t  [lanes-1:0] issue;
  alu_result_t [lanes-1:0] result;

  expect_t exp_q [$];
  data_t   hist_now  [lanes];
  data_t   hist_prev [lanes];
  int      edge_cnt      = 0;
  int      now_self_cnt  = 0;
  int      now_cross_cnt = 0;
  int      prev_cnt      = 0;
  tag_t    next_tag      = '0;

  alu_cluster #(
    .lanes(lanes)
  ) DUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (issue),
    .result (result)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic fail_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopping at the first error.");
  endtask

  function automatic data_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  // Bit by bit shift over the low width bits of v.
  function automatic data_t shift_ref(data_t v, int width, int amt, alu_op_e op);
    data_t r;
    int    src;
    r = '0;
    for (int i = 0; i < width; i++) begin
      src = (op == op_shl) ? i - amt : i + amt;
      if (src >= 0 && src < width) begin
        r[i] = v[src];
      end else if (op == op_sar) begin
        r[i] = v[width-1];
      end
    end
    return r;
  endfunction

  function automatic data_t ref_exec(alu_op_e op, logic wide, data_t a, data_t b);
    data_t r;
    int    width;
    int    amt;
    width = wide ? data_w : half_w;
    amt   = wide ? int'(b[5:0]) : int'(b[4:0]);
    case (op)
      op_add:  r = a + b;
      op_sub:  r = a - b;
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      default: r = shift_ref(a, width, amt, op);
    endcase
    // Narrow results keep only the low word.
    if (!wide) begin
      r[data_w-1:half_w] = '0;
    end
    return r;
  endfunction

  // Operand as the lane sees it, from the observed bus history.
  function automatic data_t resolve(data_t reg_val, fwd_sel_t sel);
    int idx;
    idx = int'(sel.idx);
    case (sel.src)
      fwd_now: begin
        return (idx < lanes) ? hist_now[idx] : '0;
      end
      fwd_prev: begin
        return (idx < lanes) ? hist_prev[idx] : '0;
      end
      default: begin
        return reg_val;
      end
    endcase
  endfunction

  function automatic void count_forward(int lane, fwd_sel_t sel);
    if (int'(sel.idx) < lanes) begin
      if (sel.src == fwd_now && int'(sel.idx) == lane) begin
        now_self_cnt++;
      end else if (sel.src == fwd_now) begin
        now_cross_cnt++;
      end else if (sel.src == fwd_prev) begin
        prev_cnt++;
      end
    end
  endfunction

  function automatic alu_issue_t make_op(alu_op_e op, logic wide, data_t a, data_t b);
    alu_issue_t it;
    it       = '0;
    it.valid = 1'b1;
    it.op    = op;
    it.wide  = wide;
    it.a     = a;
    it.b     = b;
    return it;
  endfunction

  function automatic alu_issue_t rand_issue();
    alu_issue_t it;
    it           = '0;
    it.valid     = ($urandom_range(0, 9) != 0);
    it.op        = alu_op_e'($urandom_range(0, 7));
    it.wide      = 1'($urandom_range(0, 1));
    it.a         = rand_word();
    it.b         = rand_word();
    it.a_fwd.src = fwd_src_e'($urandom_range(0, 2));
    it.a_fwd.idx = lane_idx_w'($urandom_range(0, lanes));
    it.b_fwd.src = fwd_src_e'($urandom_range(0, 2));
    it.b_fwd.idx = lane_idx_w'($urandom_range(0, lanes));
    return it;
  endfunction

  // Observe the bus, queue the expected results and drive the next issue.
  task automatic issue_cycle(input alu_issue_t [lanes-1:0] nxt);
    expect_t    e;
    alu_issue_t it;
    data_t      a;
    data_t      b;
    @(posedge clk);
    #1;
    for (int l = 0; l < lanes; l++) begin
      hist_prev[l] = hist_now[l];
      hist_now[l]  = result[l].data;
    end
    e     = '0;
    e.due = edge_cnt + 2;
    for (int l = 0; l < lanes; l++) begin
      it = nxt[l];
      if (it.valid) begin
        it.tag   = next_tag;
        next_tag = next_tag + 1'b1;
        count_forward(l, it.a_fwd);
        count_forward(l, it.b_fwd);
      end
      a              = resolve(it.a, it.a_fwd);
      b              = resolve(it.b, it.b_fwd);
      e.res[l].valid = it.valid;
      e.res[l].tag   = it.tag;
      e.res[l].data  = ref_exec(it.op, it.wide, a, b);
      issue[l]       = it;
    end
    exp_q.push_back(e);
  endtask

  task automatic check_lane(int lane, alu_result_t exp);
    assert (result[lane].valid == exp.valid) else begin
      $display("Mismatch at %0t: lane %0d valid %0b, expected %0b",
               $time, lane, result[lane].valid, exp.valid);
      fail_run();
    end
    if (exp.valid) begin
      assert (result[lane].tag == exp.tag) else begin
        $display("Mismatch at %0t: lane %0d tag %0d, expected %0d",
                 $time, lane, result[lane].tag, exp.tag);
        fail_run();
      end
      assert (result[lane].data == exp.data) else begin
        $display("Mismatch at %0t: lane %0d data %h, expected %h",
                 $time, lane, result[lane].data, exp.data);
        fail_run();
      end
    end
  endtask

  // Results are compared between edges, exactly two cycles after issue.
  initial begin
    expect_t e;
    forever begin
      @(negedge clk);
      if (exp_q.size() != 0 && int'(exp_q[0].due) == edge_cnt) begin
        e = exp_q.pop_front();
        for (int l = 0; l < lanes; l++) begin
          check_lane(l, e.res[l]);
        end
      end else begin
        for (int l = 0; l < lanes; l++) begin
          assert (result[l].valid == 1'b0) else begin
            $display("Mismatch at %0t: lane %0d result valid with nothing issued", $time, l);
            fail_run();
          end
        end
      end
    end
  end

  initial begin
    alu_issue_t [lanes-1:0] nxt;
    data_t                  sh_b;
    int                     wait_cnt;
    rst_n = 1'b0;
    issue = '0;
    void'($urandom(32'hffbc_b4bd));
    for (int l = 0; l < lanes; l++) begin
      hist_now[l]  = '0;
      hist_prev[l] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    nxt = '0;
    repeat (3) issue_cycle(nxt);

    // Every operation in both widths on register operands.
    for (int o = 0; o < 8; o++) begin
      for (int w = 0; w < 2; w++) begin
        nxt[0] = make_op(alu_op_e'(o), w[0], rand_word(), rand_word());
        nxt[1] = make_op(alu_op_e'(o), !w[0], rand_word(), rand_word());
        issue_cycle(nxt);
      end
    end

    // Shift amounts around both width limits, with junk above the amount field.
    for (int o = int'(op_shl); o <= int'(op_sar); o++) begin
      for (int k = 0; k < 6; k++) begin
        sh_b   = (rand_word() & ~data_t'(63)) | data_t'(shift_amts[k]);
        nxt[0] = make_op(alu_op_e'(o), 1'b0, 64'hdead_beef_8000_0f01, sh_b);
        nxt[1] = make_op(alu_op_e'(o), 1'b1, 64'h8000_0000_7fff_00f1, sh_b);
        issue_cycle(nxt);
        nxt[0].wide = 1'b1;
        nxt[1].wide = 1'b0;
        issue_cycle(nxt);
      end
    end

    // Back to back random traffic with forwarding and idle slots.
    repeat (rand_cycles) begin
      for (int l = 0; l < lanes; l++) begin
        nxt[l] = rand_issue();
      end
      issue_cycle(nxt);
    end

    assert (now_self_cnt > 0 && now_cross_cnt > 0 && prev_cnt > 0) else begin
      $display("Forwarding not exercised: now self %0d, now cross %0d, prev %0d",
               now_self_cnt, now_cross_cnt, prev_cnt);
      fail_run();
    end

    nxt = '0;
    repeat (2) issue_cycle(nxt);
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < drain_limit) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("Timed out waiting for %0d expected results", exp_q.size());
      fail_run();
    end
  end

endmodule

`default_nettype wire
